// ==== sim/prc_vectors.txt ====
# kind address data, all hex
# W is a cpu register write, M is a memory preload
W 2080 2A
W 2081 08
W 2082 05
W 2083 48
W 2084 E0
M 1360 00
M 1361 01
M 1362 02
M 1363 03
M 1378 04
M 1379 05
M 1390 06
M 4800 81
M 4801 42
M 4802 24
M 4803 18
M 4808 FF
M 4809 00
M 4810 AA
M 4811 55
M 4818 0F
M 4820 F0
M 4828 3C

// ==== vlog.f ====
+incdir+design
design/prc_pkg.sv
design/prc_bus_if.sv
design/prc_control.sv
design/prc_map_draw.sv
design/prc_frame_copy.sv
design/prc_bus_sequencer.sv
design/prc.sv
sim/prc_tb.sv

// ==== sim/prc_tb.sv ====
`include "prc_consts.svh"

module prc_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import prc_pkg::*;

    localparam int OSC         = `PRC_OSC_PERIOD;
    localparam int FRAME_TICKS = `PRC_COUNT_END;
    localparam int LCD_BLOCK   = 3 + `PRC_SCREEN_W;              // commands plus one page of data
    localparam int LCD_FRAME   = LCD_BLOCK * `PRC_PAGES;
    localparam int RENDERS     = 2;
    localparam int RENDER_CYC  = 2 * (768 * 3 * 2 + `PRC_PAGES * LCD_BLOCK * 4);  // stall margin

    logic        clk = 1'b0;
    logic        reset;
    logic        bus_write;
    logic        bus_read;
    logic [23:0] bus_address_in;
    logic [7:0]  bus_data_in;
    logic [7:0]  bus_data_out;
    logic [23:0] bus_address_out;
    bus_cmd_t    bus_status;
    logic        write;
    logic        read;
    logic        bus_request;
    logic        bus_ack;
    logic        irq_copy_complete;
    logic        irq_render_done;

    logic [7:0]  mem [0:65535];
    logic [7:0]  exp_bytes [0:767];
    logic [7:0]  reg_val [0:4];         // last value written to 0x2080..0x2084
    logic [31:0] lfsr = 32'h2121;
    int          value_errors = 0;
    int          protocol_errors = 0;
    int          divisor = 1;
    bit          loaded = 1'b0;
    longint      cycle = 0;
    longint      last_done_cycle = -1;
    int          stall_left = 0;
    int          lcd_pos = 0;
    int          lcd_total = 0;
    int          copy_irqs = 0;
    int          render_irqs = 0;
    int          requests = 0;
    logic        prev_read, prev_write, prev_req, prev_copy_irq, prev_render_irq;

    prc prc_inst
    (
        .clk(clk), .reset(reset), .bus_write(bus_write), .bus_read(bus_read),
        .bus_address_in(bus_address_in), .bus_data_in(bus_data_in),
        .bus_data_out(bus_data_out), .bus_address_out(bus_address_out),
        .bus_status(bus_status), .write(write), .read(read),
        .bus_request(bus_request), .bus_ack(bus_ack),
        .irq_copy_complete(irq_copy_complete), .irq_render_done(irq_render_done)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act)
        begin
            value_errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cmd(input string name, input bus_cmd_t exp, input bus_cmd_t act);
        if (exp !== act)
        begin
            value_errors++;
            $display("Error %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic protocol_fail(input string what);
        protocol_errors++;
        $display("at cycle %0d: %s", cycle, what);
    endtask

    // W lines are cpu writes, M lines preload memory
    task automatic load_vectors(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [23:0] a;
        logic [7:0]  d;
        fd = $fopen("sim/prc_vectors.txt", "r");
        ok = (fd != 0);
        if (ok)
        begin
            while ($fgets(line, fd))
            begin
                if (line.len() > 1 && (line.getc(0) == "W" || line.getc(0) == "M"))
                begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
                    if (n != 2)
                        protocol_fail("vector line without address and data");
                    else if (line.getc(0) == "M")
                        mem[a[15:0]] = d;
                    else
                        cpu_write(a, d);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic cpu_write(input logic [23:0] a, input logic [7:0] d);
        @(posedge clk);
        bus_write      <= 1'b1;
        bus_address_in <= a;
        bus_data_in    <= d;
        if (a >= `PRC_REG_MODE && a <= `PRC_REG_MAP_HI)
            reg_val[a - `PRC_REG_MODE] = d;
    endtask

    function automatic logic [7:0] reg_expect(input int idx);
        case (idx)
            0:       return reg_val[0] & 8'h3F;
            1:       return reg_val[1] & 8'h0F;     // skip count cleared by the new rate
            2:       return reg_val[2] & 8'hF8;
            3:       return reg_val[3];
            default: return reg_val[4] & 8'h1F;
        endcase
    endfunction

    task automatic cpu_read(input logic [23:0] a, output logic [7:0] d);
        @(posedge clk);
        bus_read       <= 1'b1;
        bus_address_in <= a;
        @(posedge clk);
        d = bus_data_out;
        bus_read <= 1'b0;
    endtask

    // map rule: tile from the map, then one column byte of that tile
    task automatic build_expected();
        int          width;
        logic [23:0] base;
        logic [7:0]  tile;
        case (reg_val[0][5:4])
            2'd0:    width = 12;
            2'd1:    width = 16;
            default: width = 24;
        endcase
        base = {3'd0, reg_val[4][4:0], reg_val[3], reg_val[2][7:3], 3'd0};
        for (int p = 0; p < `PRC_PAGES; p++)
            for (int c = 0; c < `PRC_SCREEN_W; c++)
            begin
                tile = mem[16'(`PRC_TILEMAP_BASE + p * width + c / 8)];
                exp_bytes[p * `PRC_SCREEN_W + c] = mem[16'(base + tile * 8 + c % 8)];
            end
        case (reg_val[1][3:1])
            3'd0:    divisor = 3;
            3'd1:    divisor = 6;
            3'd2:    divisor = 9;
            3'd3:    divisor = 12;
            3'd4:    divisor = 2;
            3'd5:    divisor = 4;
            3'd6:    divisor = 6;
            default: divisor = 8;
        endcase
    endtask

    task automatic check_counter();
        logic [7:0] d;
        cpu_read(`PRC_REG_COUNTER, d);
        if (d < 8'h01 || d > 8'(`PRC_COUNT_END))
            protocol_fail($sformatf("counter readback %h outside 1..42", d));
    endtask

    task automatic run_tests();
        logic [7:0] d;
        bit         ok;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        load_vectors(ok);
        if (!ok)
            protocol_fail("vector file sim/prc_vectors.txt could not be opened");
        // nothing lives at 0x2085..0x2089, so these writes must not stick
        for (int a = 24'h2085; a <= 24'h2089; a++)
            cpu_write(a, 8'hA5);
        @(posedge clk);
        bus_write <= 1'b0;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 5; i++)
        begin
            cpu_read(`PRC_REG_MODE + i, d);
            check_byte($sformatf("readback %h", `PRC_REG_MODE + i), reg_expect(i), d);
        end
        for (int a = 24'h2085; a <= 24'h2089; a++)
        begin
            cpu_read(a, d);
            check_byte($sformatf("readback %h", a), 8'h00, d);
        end
        check_counter();
        build_expected();
        loaded = 1'b1;
        while (render_irqs < RENDERS)
            @(posedge clk);
        repeat (4) @(posedge clk);
        check_counter();
        if (copy_irqs != RENDERS)
            protocol_fail($sformatf("%0d copy interrupts for %0d renders", copy_irqs, RENDERS));
        if (lcd_total != RENDERS * LCD_FRAME)
            protocol_fail($sformatf("%0d LCD writes, %0d due", lcd_total, RENDERS * LCD_FRAME));
    endtask

    // bus monitor, memory and LCD model, stall generator
    always @(posedge clk)
    begin
        cycle++;
        if (!reset)
        begin
            if (!bus_request)
            begin
                if (read || write)
                    protocol_fail("read or write strobe with no bus request");
                check_cmd("idle bus_status", CMD_IDLE, bus_status);
            end
            if ((read && prev_read) || (write && prev_write))
                protocol_fail("strobe longer than one cycle");
            if (read)
            begin
                check_cmd("read bus_status", CMD_MEM_READ, bus_status);
                bus_data_in <= mem[bus_address_out[15:0]];    // held until the next read
            end
            if (write)
            begin
                check_cmd("write bus_status", CMD_MEM_WRITE, bus_status);
                if (bus_address_out == `PRC_LCD_CMD || bus_address_out == `PRC_LCD_DATA)
                begin
                    if (lcd_pos % LCD_BLOCK < 3)
                    begin
                        if (bus_address_out != `PRC_LCD_CMD)
                            protocol_fail("LCD data byte where a page command was due");
                        case (lcd_pos % LCD_BLOCK)
                            0:       check_byte("lcd cmd", 8'h10, bus_data_out);
                            1:       check_byte("lcd cmd", 8'h00, bus_data_out);
                            default: check_byte("lcd cmd", 8'hB0 + lcd_pos / LCD_BLOCK,
                                                bus_data_out);
                        endcase
                    end
                    else
                    begin
                        if (bus_address_out != `PRC_LCD_DATA)
                            protocol_fail("LCD command where a data byte was due");
                        check_byte($sformatf("lcd data %0d", lcd_pos), exp_bytes[(lcd_pos /
                            LCD_BLOCK) * `PRC_SCREEN_W + lcd_pos % LCD_BLOCK - 3], bus_data_out);
                    end
                    lcd_pos = (lcd_pos + 1) % LCD_FRAME;
                    lcd_total++;
                end
                else
                    mem[bus_address_out[15:0]] = bus_data_out;
            end
            if (bus_request && !prev_req)
                requests++;
            if (irq_copy_complete && !prev_copy_irq)
            begin
                if (lcd_pos != 0 || lcd_total != LCD_FRAME * (copy_irqs + 1))
                    protocol_fail("copy interrupt before the last LCD byte");
                copy_irqs++;
            end
            if (irq_render_done && !prev_render_irq)
            begin
                if (requests != 1)
                    protocol_fail($sformatf("%0d renders in one rate period", requests));
                if (last_done_cycle >= 0 && cycle - last_done_cycle != divisor * FRAME_TICKS * OSC)
                    protocol_fail($sformatf("render interval of %0d cycles", cycle - last_done_cycle));
                last_done_cycle = cycle;
                requests = 0;
                render_irqs++;
            end
            if (stall_left > 0)
                stall_left--;
            else if (bus_request && cycle % 37 == 0)
            begin
                if (lfsr[0])
                    stall_left = 3;
                lfsr = lfsr_step(lfsr);
            end
            bus_ack <= bus_request && stall_left == 0;
        end
        prev_read       = read;
        prev_write      = write;
        prev_req        = bus_request;
        prev_copy_irq   = irq_copy_complete;
        prev_render_irq = irq_render_done;
    end

    initial
    begin
        wait (loaded);
        repeat (4 * FRAME_TICKS * OSC * divisor + RENDER_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, renders seen %0d", cycle, render_irqs);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        reset          = 1'b1;
        bus_write      = 1'b0;
        bus_read       = 1'b0;
        bus_address_in = '0;
        bus_data_in    = '0;
        bus_ack        = 1'b0;
        for (int i = 0; i < 5; i++)
            reg_val[i] = 8'h00;
        for (int i = 0; i < 65536; i++)
            mem[i] = i[7:0] ^ {i[12:8], i[15:13]};   // fill from the whole address
        run_tests();
        $display("value errors %0d, protocol errors %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== design/prc.sv ====
`include "prc_consts.svh"

module prc
#(
    parameter int osc_period = `PRC_OSC_PERIOD
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                bus_write,
    input  logic                bus_read,
    input  logic [23:0]         bus_address_in,
    input  logic [7:0]          bus_data_in,
    output logic [7:0]          bus_data_out,
    output logic [23:0]         bus_address_out,
    output prc_pkg::bus_cmd_t   bus_status,
    output logic                write,
    output logic                read,
    output logic                bus_request,
    input  logic                bus_ack,
    output logic                irq_copy_complete,
    output logic                irq_render_done
);
    import prc_pkg::*;

    prc_stage_t  stage;
    map_size_t   map_size;
    logic [23:0] map_base;
    logic [7:0]  reg_data_out;
    logic [7:0]  engine_data;
    logic        start_map;
    logic        start_copy;

    prc_bus_if map_bus ();
    prc_bus_if copy_bus ();

    prc_control #(.osc_period(osc_period)) u_control
    (
        .clk               (clk),
        .reset             (reset),
        .bus_write         (bus_write),
        .bus_address_in    (bus_address_in),
        .bus_data_in       (bus_data_in),
        .map_done          (map_bus.done),
        .copy_done         (copy_bus.done),
        .bus_ack           (bus_ack),
        .reg_data_out      (reg_data_out),
        .stage             (stage),
        .start_map         (start_map),
        .start_copy        (start_copy),
        .map_base          (map_base),
        .map_size          (map_size),
        .bus_request       (bus_request),
        .irq_render_done   (irq_render_done),
        .irq_copy_complete (irq_copy_complete)
    );

    prc_map_draw u_map_draw
    (
        .clk      (clk),
        .reset    (reset),
        .start    (start_map),
        .map_base (map_base),
        .map_size (map_size),
        .bus      (map_bus)
    );

    prc_frame_copy u_frame_copy
    (
        .clk   (clk),
        .reset (reset),
        .start (start_copy),
        .bus   (copy_bus)
    );

    prc_bus_sequencer u_sequencer
    (
        .clk             (clk),
        .reset           (reset),
        .bus_ack         (bus_ack),
        .stage           (stage),
        .bus_data_in     (bus_data_in),
        .map_bus         (map_bus),
        .copy_bus        (copy_bus),
        .bus_address_out (bus_address_out),
        .bus_status      (bus_status),
        .engine_data     (engine_data),
        .read            (read),
        .write           (write)
    );

    // engine data while we own the bus, register readback while the cpu reads
    assign bus_data_out = bus_ack ? engine_data : (bus_read ? reg_data_out : 8'h00);

endmodule

// ==== design/prc_bus_sequencer.sv ====
module prc_bus_sequencer
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bus_ack,
    input  prc_pkg::prc_stage_t   stage,
    input  logic [7:0]            bus_data_in,
    prc_bus_if.sequencer          map_bus,
    prc_bus_if.sequencer          copy_bus,
    output logic [23:0]           bus_address_out,
    output prc_pkg::bus_cmd_t     bus_status,
    output logic [7:0]            engine_data,
    output logic                  read,
    output logic                  write
);
    import prc_pkg::*;

    logic phase;   // 0 steps an engine, 1 runs the memory cycle

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            phase <= 1'b0;
        else if (stage == STAGE_IDLE)
            phase <= 1'b0;
        else if (bus_ack)
            phase <= ~phase;   // holds while the cpu owns the bus
    end

    assign map_bus.step   = bus_ack && !phase && (stage == STAGE_MAP_DRAW);
    assign copy_bus.step  = bus_ack && !phase && (stage == STAGE_FRAME_COPY);
    assign map_bus.rdata  = bus_data_in;
    assign copy_bus.rdata = bus_data_in;

    always_comb
    begin
        case (stage)
            STAGE_MAP_DRAW:
            begin
                bus_address_out = map_bus.address;
                bus_status      = map_bus.cmd;
                engine_data     = map_bus.wdata;
            end
            STAGE_FRAME_COPY:
            begin
                bus_address_out = copy_bus.address;
                bus_status      = copy_bus.cmd;
                engine_data     = copy_bus.wdata;
            end
            default:
            begin
                bus_address_out = '0;
                bus_status      = CMD_IDLE;
                engine_data     = 8'h00;
            end
        endcase
    end

    // single cycle strobes in phase 1
    assign read  = bus_ack && phase && (bus_status == CMD_MEM_READ);
    assign write = bus_ack && phase && (bus_status == CMD_MEM_WRITE);

endmodule

// ==== design/prc_frame_copy.sv ====
`include "prc_consts.svh"

module prc_frame_copy
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    prc_bus_if.engine  bus
);
    import prc_pkg::*;

    typedef enum logic [2:0]
    {
        FC_COL_LO = 3'd0,   // column address low nibble
        FC_COL_HI = 3'd1,
        FC_PAGE   = 3'd2,
        FC_READ   = 3'd3,
        FC_WRITE  = 3'd4,
        FC_DONE   = 3'd5
    } fc_state_t;

    localparam logic [6:0]  LAST_COL  = 7'(`PRC_SCREEN_W - 1);
    localparam logic [2:0]  LAST_PAGE = 3'(`PRC_PAGES - 1);
    localparam logic [23:0] SCREEN_W  = 24'(`PRC_SCREEN_W);

    fc_state_t   state;
    logic        active;
    logic [2:0]  page;
    logic [6:0]  col;
    logic [23:0] next_addr;
    logic [7:0]  next_data;

    always_comb
    begin
        next_addr = `PRC_LCD_CMD;
        next_data = 8'h00;
        case (state)
            FC_COL_LO: next_data = 8'h10;
            FC_PAGE:   next_data = {5'b10110, page};
            FC_READ:   next_addr = `PRC_VRAM_BASE + {21'd0, page} * SCREEN_W + {17'd0, col};
            FC_WRITE:
            begin
                next_addr = `PRC_LCD_DATA;
                next_data = bus.rdata;
            end
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (active && bus.step)
        begin
            bus.address <= next_addr;
            bus.wdata   <= next_data;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            active   <= 1'b0;
            state    <= FC_COL_LO;
            page     <= 3'd0;
            col      <= 7'd0;
            bus.cmd  <= CMD_IDLE;
            bus.done <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;
            if (start)
            begin
                active  <= 1'b1;
                state   <= FC_COL_LO;
                page    <= 3'd0;
                col     <= 7'd0;
                bus.cmd <= CMD_IDLE;
            end
            else if (active && bus.step)
            begin
                bus.cmd <= CMD_MEM_WRITE;
                case (state)
                    FC_COL_LO: state <= FC_COL_HI;
                    FC_COL_HI: state <= FC_PAGE;
                    FC_PAGE:   state <= FC_READ;
                    FC_READ:
                    begin
                        bus.cmd <= CMD_MEM_READ;
                        state   <= FC_WRITE;
                    end
                    FC_WRITE:
                    begin
                        state <= FC_READ;
                        col   <= col + 1'b1;
                        if (col == LAST_COL)
                        begin
                            col   <= 7'd0;
                            state <= FC_COL_LO;   // next page starts with its commands
                            if (page == LAST_PAGE)
                                state <= FC_DONE;
                            else
                                page <= page + 1'b1;
                        end
                    end
                    default:
                    begin
                        bus.cmd  <= CMD_IDLE;
                        bus.done <= 1'b1;
                        active   <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

// ==== design/prc_map_draw.sv ====
`include "prc_consts.svh"

module prc_map_draw
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic [23:0]          map_base,
    input  prc_pkg::map_size_t   map_size,
    prc_bus_if.engine            bus
);
    import prc_pkg::*;

    typedef enum logic [1:0]
    {
        MD_TILE  = 2'd0,   // read tile number from the map
        MD_BYTE  = 2'd1,   // read one column of the tile
        MD_WRITE = 2'd2,   // store it into vram
        MD_DONE  = 2'd3
    } md_state_t;

    localparam logic [6:0]  LAST_COL  = 7'(`PRC_SCREEN_W - 1);
    localparam logic [2:0]  LAST_PAGE = 3'(`PRC_PAGES - 1);
    localparam logic [23:0] SCREEN_W  = 24'(`PRC_SCREEN_W);

    md_state_t   state;
    logic        active;
    logic [2:0]  page;
    logic [6:0]  col;
    logic [23:0] row_off;
    logic [23:0] next_addr;

    assign row_off = {21'd0, page} * {19'd0, map_size.width};

    always_comb
    begin
        case (state)
            MD_TILE:  next_addr = `PRC_TILEMAP_BASE + row_off + {20'd0, col[6:3]};
            MD_BYTE:  next_addr = map_base + {13'd0, bus.rdata, 3'd0} + {21'd0, col[2:0]};
            MD_WRITE: next_addr = `PRC_VRAM_BASE + {21'd0, page} * SCREEN_W + {17'd0, col};
            default:  next_addr = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (active && bus.step)
        begin
            bus.address <= next_addr;
            bus.wdata   <= bus.rdata;   // only used on the vram write
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            active   <= 1'b0;
            state    <= MD_TILE;
            page     <= 3'd0;
            col      <= 7'd0;
            bus.cmd  <= CMD_IDLE;
            bus.done <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;
            if (start)
            begin
                active  <= 1'b1;
                state   <= MD_TILE;
                page    <= 3'd0;
                col     <= 7'd0;
                bus.cmd <= CMD_IDLE;
            end
            else if (active && bus.step)
            begin
                case (state)
                    MD_TILE:
                    begin
                        bus.cmd <= CMD_MEM_READ;
                        state   <= MD_BYTE;
                    end
                    MD_BYTE:
                        state <= MD_WRITE;
                    MD_WRITE:
                    begin
                        bus.cmd <= CMD_MEM_WRITE;
                        state   <= MD_TILE;
                        col     <= col + 1'b1;
                        if (col == LAST_COL)
                        begin
                            col <= 7'd0;
                            if (page == LAST_PAGE)
                                state <= MD_DONE;
                            else
                                page <= page + 1'b1;
                        end
                    end
                    default:
                    begin
                        bus.cmd  <= CMD_IDLE;   // last write went out in the previous phase 1
                        bus.done <= 1'b1;
                        active   <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

// ==== design/prc_control.sv ====
`include "prc_consts.svh"

module prc_control
#(
    parameter int osc_period = `PRC_OSC_PERIOD
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bus_write,
    input  logic [23:0]           bus_address_in,
    input  logic [7:0]            bus_data_in,
    input  logic                  map_done,
    input  logic                  copy_done,
    input  logic                  bus_ack,
    output logic [7:0]            reg_data_out,
    output prc_pkg::prc_stage_t   stage,
    output logic                  start_map,
    output logic                  start_copy,
    output logic [23:0]           map_base,
    output prc_pkg::map_size_t    map_size,
    output logic                  bus_request,
    output logic                  irq_render_done,
    output logic                  irq_copy_complete
);
    import prc_pkg::*;

    localparam int OSC_W = $clog2(osc_period);

    logic [5:0]       reg_mode;
    logic [7:0]       reg_rate;      // skip count in 7:4, rate field in 3:1
    logic [20:3]      reg_map_base;
    logic [6:0]       reg_counter;
    logic [OSC_W-1:0] osc_cnt;
    logic             tick;
    logic [3:0]       rate_match;
    prc_stage_t       nxt;
    logic             wr_pending;
    logic [23:0]      wr_addr;
    logic [7:0]       wr_data;

    function automatic prc_stage_t next_stage(input prc_stage_t cur, input logic [5:0] mode);
        prc_stage_t n;
        n = STAGE_IDLE;
        if (cur == STAGE_IDLE && mode[1])
            n = STAGE_MAP_DRAW;
        else if (cur != STAGE_FRAME_COPY && mode[3])
            n = STAGE_FRAME_COPY;
        return n;
    endfunction

    assign nxt      = next_stage(stage, reg_mode);
    assign tick     = (osc_cnt == OSC_W'(osc_period - 1));
    assign map_base = {3'd0, reg_map_base, 3'd0};

    always_comb
    begin
        case (reg_mode[5:4])
            2'd0:    map_size = '{width: 5'd12, height: 5'd16};
            2'd1:    map_size = '{width: 5'd16, height: 5'd12};
            2'd2:    map_size = '{width: 5'd24, height: 5'd8};
            default: map_size = '{width: 5'd24, height: 5'd16};
        endcase
    end

    // frames to skip between renders
    always_comb
    begin
        case (reg_rate[3:1])
            3'd0:    rate_match = 4'h2;
            3'd1:    rate_match = 4'h5;
            3'd2:    rate_match = 4'h8;
            3'd3:    rate_match = 4'hB;
            3'd4:    rate_match = 4'h1;
            3'd5:    rate_match = 4'h3;
            3'd6:    rate_match = 4'h5;
            default: rate_match = 4'h7;
        endcase
    end

    always_comb
    begin
        case (bus_address_in)
            `PRC_REG_MODE:    reg_data_out = {2'd0, reg_mode};
            `PRC_REG_RATE:    reg_data_out = reg_rate;
            `PRC_REG_MAP_LO:  reg_data_out = map_base[7:0];
            `PRC_REG_MAP_MID: reg_data_out = map_base[15:8];
            `PRC_REG_MAP_HI:  reg_data_out = map_base[23:16];
            `PRC_REG_COUNTER: reg_data_out = {1'b0, reg_counter};
            default:          reg_data_out = 8'h00;
        endcase
    end

    // cpu write is applied one cycle after the strobe
    always_ff @(posedge clk)
    begin
        wr_addr <= bus_address_in;
        wr_data <= bus_data_in;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_pending        <= 1'b0;
            reg_mode          <= 6'd0;
            reg_rate          <= 8'd0;
            reg_map_base      <= '0;
            reg_counter       <= 7'd1;
            osc_cnt           <= '0;
            stage             <= STAGE_IDLE;
            start_map         <= 1'b0;
            start_copy        <= 1'b0;
            bus_request       <= 1'b0;
            irq_render_done   <= 1'b0;
            irq_copy_complete <= 1'b0;
        end
        else
        begin
            wr_pending <= bus_write;
            start_map  <= 1'b0;
            start_copy <= 1'b0;

            if (wr_pending)
            begin
                case (wr_addr)
                    `PRC_REG_MODE:    reg_mode <= wr_data[5:0];
                    `PRC_REG_RATE:
                        // a new rate field restarts the skip count
                        reg_rate <= (reg_rate[3:1] != wr_data[3:1]) ?
                            {4'd0, wr_data[3:0]} : {reg_rate[7:4], wr_data[3:0]};
                    `PRC_REG_MAP_LO:  reg_map_base[7:3]   <= wr_data[7:3];
                    `PRC_REG_MAP_MID: reg_map_base[15:8]  <= wr_data;
                    `PRC_REG_MAP_HI:  reg_map_base[20:16] <= wr_data[4:0];
                    default:
                    begin
                    end
                endcase
            end

            osc_cnt <= osc_cnt + 1'b1;
            if (tick)
            begin
                osc_cnt           <= '0;
                reg_counter       <= reg_counter + 1'b1;
                irq_render_done   <= 1'b0;
                irq_copy_complete <= 1'b0;

                if (reg_rate[7:4] == rate_match)
                begin
                    if (reg_counter == `PRC_COUNT_END)
                    begin
                        bus_request     <= 1'b0;
                        reg_counter     <= 7'd1;
                        reg_rate[7:4]   <= 4'd0;
                        irq_render_done <= 1'b1;
                    end
                    else if (reg_counter >= `PRC_COUNT_START && !bus_request && !bus_ack &&
                             stage == STAGE_IDLE && (reg_mode[1] || reg_mode[3]))
                    begin
                        bus_request <= 1'b1;
                        stage       <= nxt;
                        start_map   <= (nxt == STAGE_MAP_DRAW);
                        start_copy  <= (nxt == STAGE_FRAME_COPY);
                    end
                end
                else if (reg_counter == `PRC_COUNT_END)
                begin
                    reg_counter   <= 7'd1;
                    reg_rate[7:4] <= reg_rate[7:4] + 1'b1;   // skipped frame
                end
            end

            // hand the bus to the next enabled engine
            if ((stage == STAGE_MAP_DRAW && map_done) ||
                (stage == STAGE_FRAME_COPY && copy_done))
            begin
                stage      <= nxt;
                start_map  <= (nxt == STAGE_MAP_DRAW);
                start_copy <= (nxt == STAGE_FRAME_COPY);
                if (stage == STAGE_FRAME_COPY)
                    irq_copy_complete <= 1'b1;
            end
        end
    end

endmodule

// ==== design/prc_bus_if.sv ====
interface prc_bus_if;
    import prc_pkg::*;

    logic        step;     // phase 0 strobe from the sequencer
    logic [23:0] address;
    bus_cmd_t    cmd;
    logic [7:0]  wdata;
    logic [7:0]  rdata;    // memory data, valid during step
    logic        done;     // end of pass

    modport engine
    (
        input  step,
        input  rdata,
        output address,
        output cmd,
        output wdata,
        output done
    );

    modport sequencer
    (
        output step,
        output rdata,
        input  address,
        input  cmd,
        input  wdata
    );

endinterface

// ==== design/prc_pkg.sv ====
package prc_pkg;

    // which engine owns the bus
    typedef enum logic [1:0]
    {
        STAGE_IDLE       = 2'd0,
        STAGE_MAP_DRAW   = 2'd1,
        STAGE_FRAME_COPY = 2'd2
    } prc_stage_t;

    // bus_status encoding, same values as the cpu side expects
    typedef enum logic [1:0]
    {
        CMD_IDLE      = 2'd0,
        CMD_MEM_WRITE = 2'd2,
        CMD_MEM_READ  = 2'd3
    } bus_cmd_t;

    // map dimensions in tiles
    typedef struct packed
    {
        logic [4:0] width;
        logic [4:0] height;
    } map_size_t;

endpackage

// ==== design/prc_consts.svh ====
`ifndef PRC_CONSTS_SVH
`define PRC_CONSTS_SVH

// cpu register map
`define PRC_REG_MODE     24'h2080
`define PRC_REG_RATE     24'h2081
`define PRC_REG_MAP_LO   24'h2082
`define PRC_REG_MAP_MID  24'h2083
`define PRC_REG_MAP_HI   24'h2084
`define PRC_REG_COUNTER  24'h208A

// bus addresses used by the engines
`define PRC_VRAM_BASE    24'h1000
`define PRC_TILEMAP_BASE 24'h1360
`define PRC_LCD_CMD      24'h20FE
`define PRC_LCD_DATA     24'h20FF

// screen geometry, 8 pixel pages
`define PRC_SCREEN_W     96
`define PRC_PAGES        8

// frame counter window
`define PRC_COUNT_START  7'h18
`define PRC_COUNT_END    7'h42

// clock cycles per counter tick
`define PRC_OSC_PERIOD   855

`endif
